// ==== verilog/mrr_loopback_pkg.sv ====
package mrr_loopback_pkg;

    // receive sampling and bit framing
    localparam int ESAMP_WIDTH = 16;
    localparam int SAMPLES_PER_CHIP = 4;
    localparam int BIT_CHIPS = 8;
    localparam int ACCUM_WIDTH = ESAMP_WIDTH + 4;
    localparam int SAMP_CNT_WIDTH = $clog2(SAMPLES_PER_CHIP);
    localparam int CHIP_IDX_WIDTH = $clog2(BIT_CHIPS);

    // preamble correlation
    localparam int PN_SEQ_LEN = 15;
    localparam logic [PN_SEQ_LEN-1:0] PN_SEQ = 15'b000100110101111;
    localparam int PN_IDX_WIDTH = $clog2(PN_SEQ_LEN);
    localparam int SEARCH_OFFSETS = 16;
    localparam int OFFSET_WIDTH = 4;
    localparam int PREAMBLE_BITS = SEARCH_OFFSETS + PN_SEQ_LEN;
    localparam int BIT_ADDR_WIDTH = 5;
    // score range is -PN_SEQ_LEN..PN_SEQ_LEN
    localparam int SCORE_WIDTH = PN_IDX_WIDTH + 2;

    // loopback transmit
    localparam int TX_BITS = 32;
    localparam int TX_BIT_WIDTH = $clog2(TX_BITS);
    localparam int TX_CHIPS_PER_BIT = 4;
    localparam int TX_CHIP_WIDTH = $clog2(TX_CHIPS_PER_BIT);
    localparam int TICK_CNT_WIDTH = $clog2(SAMPLES_PER_CHIP);

    // loopback clock runs at 25/32 of the sample rate
    localparam int LOOP_STEP = 25;
    localparam int LOOP_WRAP = 32;
    localparam int LOOP_ACC_WIDTH = 8;

    localparam int PAYLOAD_CNT_WIDTH = 8;
    localparam int RX_CNT_WIDTH = PAYLOAD_CNT_WIDTH + 1;
    localparam int WAIT_WIDTH = 16;

    typedef struct packed {
        logic [PAYLOAD_CNT_WIDTH-1:0] num_payload_bits;
        logic [WAIT_WIDTH-1:0]        wait_chips;
        logic [TX_BITS-1:0]           tx_word;
        logic                         tx_disable;
    } loop_cfg_t;

    typedef struct packed {
        logic [CHIP_IDX_WIDTH-1:0] chip_idx;
        logic                      chip_strobe;
        logic                      bit_end;
        logic [TX_CHIP_WIDTH-1:0]  tx_chip;
        logic                      tx_strobe;
    } chip_pos_t;

    typedef struct packed {
        logic valid;
        logic value;
    } bit_dec_t;

endpackage

// ==== verilog/chip_timer.sv ====
`timescale 1ns/1ps

module chip_timer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_sample_valid,
    input  logic                          i_rx_run,
    input  logic                          i_tx_run,
    output mrr_loopback_pkg::chip_pos_t   o_pos
);
    import mrr_loopback_pkg::*;

    logic [SAMP_CNT_WIDTH-1:0] samp_cnt;
    logic [LOOP_ACC_WIDTH-1:0] loop_acc;
    logic                      loop_tick;
    logic [TICK_CNT_WIDTH-1:0] tick_cnt;

    // fractional loopback clock, drains only on idle sample slots
    always_ff @(posedge clk) begin
        if (rst) begin
            loop_acc  <= '0;
            loop_tick <= 1'b0;
        end else begin
            loop_tick <= 1'b0;
            if (i_sample_valid) begin
                loop_acc <= loop_acc + LOOP_ACC_WIDTH'(LOOP_STEP);
            end else if (loop_acc >= LOOP_ACC_WIDTH'(LOOP_WRAP)) begin
                loop_acc  <= loop_acc - LOOP_ACC_WIDTH'(LOOP_WRAP);
                loop_tick <= 1'b1;
            end
        end
    end

    // receive chips, counted in valid samples
    always_ff @(posedge clk) begin
        if (rst || !i_rx_run) begin
            samp_cnt          <= '0;
            o_pos.chip_idx    <= '0;
            o_pos.chip_strobe <= 1'b0;
            o_pos.bit_end     <= 1'b0;
        end else begin
            o_pos.chip_strobe <= 1'b0;
            o_pos.bit_end     <= 1'b0;
            if (i_sample_valid) begin
                samp_cnt <= samp_cnt + 1'b1;
                if (samp_cnt == SAMP_CNT_WIDTH'(SAMPLES_PER_CHIP - 1)) begin
                    samp_cnt          <= '0;
                    o_pos.chip_strobe <= 1'b1;
                    o_pos.chip_idx    <= o_pos.chip_idx + 1'b1;
                    if (o_pos.chip_idx == CHIP_IDX_WIDTH'(BIT_CHIPS - 1)) begin
                        o_pos.chip_idx <= '0;
                        o_pos.bit_end  <= 1'b1;
                    end
                end
            end
        end
    end

    // transmit chips, counted in loopback ticks
    always_ff @(posedge clk) begin
        if (rst || !i_tx_run) begin
            tick_cnt        <= '0;
            o_pos.tx_chip   <= '0;
            o_pos.tx_strobe <= 1'b0;
        end else begin
            o_pos.tx_strobe <= 1'b0;
            if (loop_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (tick_cnt == TICK_CNT_WIDTH'(SAMPLES_PER_CHIP - 1)) begin
                    tick_cnt        <= '0;
                    o_pos.tx_strobe <= 1'b1;
                    o_pos.tx_chip   <= o_pos.tx_chip + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/chip_energy.sv ====
`timescale 1ns/1ps

module chip_energy (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [mrr_loopback_pkg::ESAMP_WIDTH-1:0]   i_sample,
    input  logic                                       i_sample_valid,
    input  mrr_loopback_pkg::chip_pos_t                i_pos,
    output mrr_loopback_pkg::bit_dec_t                 o_dec
);
    import mrr_loopback_pkg::*;

    logic [ACCUM_WIDTH-1:0] zero_acc;
    logic [ACCUM_WIDTH-1:0] one_acc;
    logic                   in_silent;
    logic                   in_zero;
    logic                   in_one;

    // chip pairs: 0-1 silent, 2-3 zero slot, 4-5 one slot, 6-7 recharge
    assign in_silent = (i_pos.chip_idx[CHIP_IDX_WIDTH-1:1] == 2'd0);
    assign in_zero   = (i_pos.chip_idx[CHIP_IDX_WIDTH-1:1] == 2'd1);
    assign in_one    = (i_pos.chip_idx[CHIP_IDX_WIDTH-1:1] == 2'd2);

    // silent chips hold both sums at zero, which also clears them after bit_end
    always_ff @(posedge clk) begin
        if (in_silent) begin
            zero_acc <= '0;
            one_acc  <= '0;
        end else if (i_sample_valid) begin
            if (in_zero) begin
                zero_acc <= zero_acc + ACCUM_WIDTH'(i_sample);
            end
            if (in_one) begin
                one_acc <= one_acc + ACCUM_WIDTH'(i_sample);
            end
        end
    end

    // bit_end arrives with chip_idx already at 0, sums are still intact
    always_ff @(posedge clk) begin
        if (rst) begin
            o_dec <= '0;
        end else begin
            o_dec.valid <= i_pos.bit_end;
            if (i_pos.bit_end) begin
                o_dec.value <= (one_acc > zero_acc);
            end
        end
    end

endmodule

// ==== verilog/pn_search.sv ====
`timescale 1ns/1ps

module pn_search (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        i_rx_run,
    input  mrr_loopback_pkg::bit_dec_t                  i_dec,
    output logic                                        o_done,
    output logic [mrr_loopback_pkg::OFFSET_WIDTH-1:0]   o_offset
);
    import mrr_loopback_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CORR,
        S_DRAIN,
        S_UPDATE,
        S_DONE
    } search_state_t;

    search_state_t state;

    logic                          bit_mem [PREAMBLE_BITS];
    logic [BIT_ADDR_WIDTH-1:0]     wr_cnt;
    logic                          wr_en;
    logic [BIT_ADDR_WIDTH-1:0]     rd_addr;
    logic                          rd_bit;
    logic                          start;
    logic                          acc_en;
    logic                          acc_en_d;
    logic [OFFSET_WIDTH-1:0]       off;
    logic [PN_IDX_WIDTH-1:0]       sub;
    logic [PN_SEQ_LEN-1:0]         pn_sh;
    logic signed [SCORE_WIDTH-1:0] score;
    logic signed [SCORE_WIDTH-1:0] best_score;
    logic [OFFSET_WIDTH-1:0]       best_off;

    assign wr_en   = i_rx_run && i_dec.valid && (wr_cnt < BIT_ADDR_WIDTH'(PREAMBLE_BITS));
    assign start   = wr_en && (wr_cnt == BIT_ADDR_WIDTH'(PREAMBLE_BITS - 1)) && (state == S_IDLE);
    assign rd_addr = BIT_ADDR_WIDTH'(off) + BIT_ADDR_WIDTH'(sub);
    assign acc_en  = (state == S_CORR);

    // preamble bit store, registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bit_mem[wr_cnt] <= i_dec.value;
        end
        rd_bit <= bit_mem[rd_addr];
    end

    // correlation datapath, read data lags the address by one cycle
    always_ff @(posedge clk) begin
        if (start) begin
            off        <= '0;
            sub        <= '0;
            score      <= '0;
            pn_sh      <= PN_SEQ;
            best_score <= '1;
            best_off   <= '0;
        end else begin
            if (acc_en) begin
                sub <= sub + 1'b1;
            end
            if (acc_en_d) begin
                pn_sh <= {pn_sh[PN_SEQ_LEN-2:0], 1'b0};
                if (rd_bit == pn_sh[PN_SEQ_LEN-1]) begin
                    score <= score + SCORE_WIDTH'(1);
                end else begin
                    score <= score - SCORE_WIDTH'(1);
                end
            end
            if (state == S_UPDATE) begin
                // strict compare keeps the lowest offset on a tie
                if (score > best_score) begin
                    best_score <= score;
                    best_off   <= off;
                end
                off   <= off + 1'b1;
                sub   <= '0;
                score <= '0;
                pn_sh <= PN_SEQ;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            wr_cnt   <= '0;
            acc_en_d <= 1'b0;
            o_done   <= 1'b0;
            o_offset <= '0;
        end else begin
            acc_en_d <= acc_en;
            o_done   <= 1'b0;
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_CORR;
                    end
                end
                S_CORR: begin
                    if (sub == PN_IDX_WIDTH'(PN_SEQ_LEN - 1)) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    state <= S_UPDATE;
                end
                S_UPDATE: begin
                    if (off == OFFSET_WIDTH'(SEARCH_OFFSETS - 1)) begin
                        state <= S_DONE;
                    end else begin
                        state <= S_CORR;
                    end
                end
                S_DONE: begin
                    o_done   <= 1'b1;
                    o_offset <= best_off;
                    state    <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
            // receive finished or aborted
            if (!i_rx_run) begin
                state    <= S_IDLE;
                wr_cnt   <= '0;
                o_offset <= '0;
            end
        end
    end

endmodule

// ==== verilog/loopback_ctrl.sv ====
`timescale 1ns/1ps

module loopback_ctrl (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        i_fm_flag,
    input  mrr_loopback_pkg::loop_cfg_t                 i_cfg,
    input  mrr_loopback_pkg::chip_pos_t                 i_pos,
    input  mrr_loopback_pkg::bit_dec_t                  i_dec,
    input  logic                                        i_pn_done,
    input  logic [mrr_loopback_pkg::OFFSET_WIDTH-1:0]   i_pn_offset,
    output logic                                        o_rx_run,
    output logic                                        o_tx_run,
    output logic                                        o_busy,
    output logic                                        o_pn_valid,
    output logic                                        o_tx_en,
    output logic                                        o_tx_key
);
    import mrr_loopback_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RX,
        ST_TURN,
        ST_TX
    } ctrl_state_t;

    ctrl_state_t state;

    logic [RX_CNT_WIDTH-1:0]  rx_bits;
    logic [RX_CNT_WIDTH-1:0]  rx_next;
    logic [WAIT_WIDTH-1:0]    wait_cnt;
    logic [TX_BIT_WIDTH-1:0]  tx_bit;
    logic [TX_CHIP_WIDTH-1:0] tx_rel;
    logic                     rx_last;
    logic                     turn_last;
    logic                     tx_bit_end;
    logic                     cur_bit;

    assign rx_next = rx_bits + 1'b1;
    assign rx_last = i_dec.valid && o_pn_valid &&
                     ((rx_next - RX_CNT_WIDTH'(i_pn_offset)) ==
                      RX_CNT_WIDTH'(i_cfg.num_payload_bits));

    assign turn_last = (i_cfg.wait_chips == '0) ||
                       (i_pos.tx_strobe && (wait_cnt == i_cfg.wait_chips - 1'b1));

    // tx chip counter keeps running from turnaround, so realign it to the first tx bit
    assign tx_rel     = i_pos.tx_chip - i_cfg.wait_chips[TX_CHIP_WIDTH-1:0];
    assign tx_bit_end = i_pos.tx_strobe && (tx_rel == '0);
    assign cur_bit    = i_cfg.tx_word[tx_bit];

    assign o_rx_run = (state == ST_RX);
    assign o_tx_run = (state == ST_TURN) || (state == ST_TX);
    assign o_busy   = (state != ST_IDLE);
    assign o_tx_en  = o_tx_run && !i_cfg.tx_disable;
    // a one keys the first chip pair, a zero the second
    assign o_tx_key = (state == ST_TX) && !i_cfg.tx_disable &&
                      (cur_bit ^ tx_rel[TX_CHIP_WIDTH-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            o_pn_valid <= 1'b0;
            rx_bits    <= '0;
            wait_cnt   <= '0;
            tx_bit     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    o_pn_valid <= 1'b0;
                    rx_bits    <= '0;
                    wait_cnt   <= '0;
                    tx_bit     <= '0;
                    if (i_fm_flag) begin
                        state <= ST_RX;
                    end
                end
                ST_RX: begin
                    if (i_pn_done) begin
                        o_pn_valid <= 1'b1;
                    end
                    if (i_dec.valid) begin
                        rx_bits <= rx_next;
                    end
                    if (rx_last) begin
                        state <= ST_TURN;
                    end
                end
                ST_TURN: begin
                    if (turn_last) begin
                        state <= ST_TX;
                    end else if (i_pos.tx_strobe) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_TX: begin
                    if (tx_bit_end) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == TX_BIT_WIDTH'(TX_BITS - 1)) begin
                            state      <= ST_IDLE;
                            o_pn_valid <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/mrr_loopback_top.sv ====
`timescale 1ns/1ps

module mrr_loopback_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [mrr_loopback_pkg::ESAMP_WIDTH-1:0]    i_sample,
    input  logic                                        i_sample_valid,
    input  logic                                        i_fm_flag,
    input  mrr_loopback_pkg::loop_cfg_t                 i_cfg,
    output logic                                        o_busy,
    output logic                                        o_bit_valid,
    output logic                                        o_bit,
    output logic                                        o_pn_valid,
    output logic [mrr_loopback_pkg::OFFSET_WIDTH-1:0]   o_pn_offset,
    output logic                                        o_tx_en,
    output logic                                        o_tx_key
);
    import mrr_loopback_pkg::*;

    chip_pos_t pos;
    bit_dec_t  dec;
    logic      rx_run;
    logic      tx_run;
    logic      pn_done;

    assign o_bit_valid = dec.valid;
    assign o_bit       = dec.value;

    chip_timer u_chip_timer (
        .clk            (clk),
        .rst            (rst),
        .i_sample_valid (i_sample_valid),
        .i_rx_run       (rx_run),
        .i_tx_run       (tx_run),
        .o_pos          (pos)
    );

    chip_energy u_chip_energy (
        .clk            (clk),
        .rst            (rst),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .i_pos          (pos),
        .o_dec          (dec)
    );

    pn_search u_pn_search (
        .clk      (clk),
        .rst      (rst),
        .i_rx_run (rx_run),
        .i_dec    (dec),
        .o_done   (pn_done),
        .o_offset (o_pn_offset)
    );

    loopback_ctrl u_loopback_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_fm_flag   (i_fm_flag),
        .i_cfg       (i_cfg),
        .i_pos       (pos),
        .i_dec       (dec),
        .i_pn_done   (pn_done),
        .i_pn_offset (o_pn_offset),
        .o_rx_run    (rx_run),
        .o_tx_run    (tx_run),
        .o_busy      (o_busy),
        .o_pn_valid  (o_pn_valid),
        .o_tx_en     (o_tx_en),
        .o_tx_key    (o_tx_key)
    );

endmodule

// ==== verification/mrr_loopback_chk.sv ====
`timescale 1ns/1ps

module mrr_loopback_chk (
    input logic clk,
    input logic rst,
    input logic i_busy,
    input logic i_bit_valid,
    input logic i_pn_valid,
    input logic i_tx_en,
    input logic i_tx_key
);

    // keying is only legal while the transmitter is enabled
    key_needs_en: assert property (@(posedge clk) disable iff (rst) i_tx_key |-> i_tx_en)
        else $error("o_tx_key high while o_tx_en is low");

    en_needs_busy: assert property (@(posedge clk) disable iff (rst) i_tx_en |-> i_busy)
        else $error("o_tx_en high while o_busy is low");

    // bit decisions are at least one bit period apart
    single_bit_pulse: assert property (@(posedge clk) disable iff (rst)
        i_bit_valid |=> !i_bit_valid)
        else $error("o_bit_valid high for two cycles in a row");

    pn_needs_busy: assert property (@(posedge clk) disable iff (rst) i_pn_valid |-> i_busy)
        else $error("o_pn_valid high while o_busy is low");

endmodule

bind mrr_loopback_top mrr_loopback_chk chk0 (
    .clk         (clk),
    .rst         (rst),
    .i_busy      (o_busy),
    .i_bit_valid (o_bit_valid),
    .i_pn_valid  (o_pn_valid),
    .i_tx_en     (o_tx_en),
    .i_tx_key    (o_tx_key)
);

// ==== verification/mrr_loopback_tb.sv ====
`timescale 1ns/1ps

module mrr_loopback_tb;
    import mrr_loopback_pkg::*;

    localparam int NUM_ROWS = 5;
    localparam int MAX_BITS = 96;
    localparam int SAMPLE_LIMIT = 40000;

    typedef struct packed {
        logic [15:0] filler;
        logic [4:0]  place_off;
        logic [7:0]  num_payload;
        logic [63:0] payload;
        logic [15:0] wait_chips;
        logic [31:0] tx_word;
        logic        tx_disable;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [ESAMP_WIDTH-1:0] i_sample;
    logic                   i_sample_valid;
    logic                   i_fm_flag;
    loop_cfg_t              i_cfg;
    logic                   o_busy;
    logic                   o_bit_valid;
    logic                   o_bit;
    logic                   o_pn_valid;
    logic [OFFSET_WIDTH-1:0] o_pn_offset;
    logic                   o_tx_en;
    logic                   o_tx_key;

    row_t   table_rows [NUM_ROWS];
    logic   stream [MAX_BITS];
    integer seed;
    int     errors;
    int     passed;
    int     failed;
    logic   timed_out;

    // monitor state
    logic   mon_on;
    logic   bits_q[$];
    logic   chips_q[$];
    logic   pn_seen;
    logic [OFFSET_WIDTH-1:0] pn_got;
    logic   en_seen;
    logic   key_seen;
    int     loop_acc;
    logic   loop_tick;
    int     tick_cnt;

    mrr_loopback_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .i_fm_flag      (i_fm_flag),
        .i_cfg          (i_cfg),
        .o_busy         (o_busy),
        .o_bit_valid    (o_bit_valid),
        .o_bit          (o_bit),
        .o_pn_valid     (o_pn_valid),
        .o_pn_offset    (o_pn_offset),
        .o_tx_en        (o_tx_en),
        .o_tx_key       (o_tx_key)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model of the loopback clock that ticks only on idle sample slots
    always @(posedge clk) begin
        if (rst) begin
            loop_acc  = 0;
            loop_tick = 1'b0;
            tick_cnt  = 0;
        end else begin
            if (mon_on) begin
                if (o_bit_valid) begin
                    bits_q.push_back(o_bit);
                end
                if (o_pn_valid && !pn_seen) begin
                    pn_seen = 1'b1;
                    pn_got  = o_pn_offset;
                end
                en_seen  = en_seen | o_tx_en;
                key_seen = key_seen | o_tx_key;
            end
            // key is sampled at the end of each 4-tick transmit chip
            if (!o_tx_en) begin
                tick_cnt = 0;
            end else if (loop_tick) begin
                if (tick_cnt == SAMPLES_PER_CHIP - 1) begin
                    tick_cnt = 0;
                    if (mon_on) begin
                        chips_q.push_back(o_tx_key);
                    end
                end else begin
                    tick_cnt = tick_cnt + 1;
                end
            end
            loop_tick = 1'b0;
            if (i_sample_valid) begin
                loop_acc = loop_acc + LOOP_STEP;
            end else if (loop_acc >= LOOP_WRAP) begin
                loop_acc  = loop_acc - LOOP_WRAP;
                loop_tick = 1'b1;
            end
        end
    end

    task automatic drive_sample(input logic [ESAMP_WIDTH-1:0] value);
        int gap;
        gap = 1 + ($unsigned($random(seed)) % 3);
        i_sample       = value;
        i_sample_valid = 1'b1;
        @(posedge clk);
        #1;
        i_sample_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // high energy in the zero slot (chips 2-3) or the one slot (chips 4-5)
    task automatic send_bit(input logic value);
        logic hot;
        for (int chip = 0; chip < BIT_CHIPS; chip++) begin
            hot = value ? (chip == 4 || chip == 5) : (chip == 2 || chip == 3);
            for (int s = 0; s < SAMPLES_PER_CHIP; s++) begin
                if (hot) begin
                    drive_sample(16'd900 + ($unsigned($random(seed)) % 64));
                end else begin
                    drive_sample($unsigned($random(seed)) % 16);
                end
            end
        end
    endtask

    function automatic int offset_model();
        int best;
        int best_off;
        int score;
        best     = -1;
        best_off = 0;
        for (int o = 0; o < SEARCH_OFFSETS; o++) begin
            score = 0;
            for (int k = 0; k < PN_SEQ_LEN; k++) begin
                score += (stream[o + k] == PN_SEQ[PN_SEQ_LEN - 1 - k]) ? 1 : -1;
            end
            if (score > best) begin
                best     = score;
                best_off = o;
            end
        end
        return best_off;
    endfunction

    task automatic run_packet(input int idx);
        row_t r;
        int   total;
        int   exp_off;
        int   n;
        int   start_errors;
        logic exp_key;
        r = table_rows[idx];
        start_errors = errors;
        for (int i = 0; i < MAX_BITS; i++) begin
            if (i < r.place_off) begin
                stream[i] = r.filler[i];
            end else if (i < r.place_off + PN_SEQ_LEN) begin
                stream[i] = PN_SEQ[PN_SEQ_LEN - 1 - (i - r.place_off)];
            end else begin
                stream[i] = r.payload[i - r.place_off - PN_SEQ_LEN];
            end
        end
        exp_off = offset_model();
        total   = exp_off + r.num_payload;
        bits_q.delete();
        chips_q.delete();
        pn_seen  = 1'b0;
        en_seen  = 1'b0;
        key_seen = 1'b0;
        mon_on   = 1'b1;
        i_cfg = '{num_payload_bits: r.num_payload, wait_chips: r.wait_chips,
                  tx_word: r.tx_word, tx_disable: r.tx_disable};
        i_fm_flag = 1'b1;
        @(posedge clk);
        #1;
        i_fm_flag = 1'b0;
        for (int b = 0; b < total; b++) begin
            send_bit(stream[b]);
        end
        // samples keep flowing because they also clock the loopback transmitter
        n = 0;
        while (o_busy && n < SAMPLE_LIMIT) begin
            drive_sample(16'd5);
            n++;
        end
        mon_on = 1'b0;
        if (n >= SAMPLE_LIMIT) begin
            $display("timeout: packet %0d never returned to idle", idx);
            timed_out = 1'b1;
            errors++;
            failed++;
        end else begin
            assert (bits_q.size() == total)
                else begin
                    $display("MISMATCH %0t: packet %0d got %0d bits, expected %0d",
                             $time, idx, bits_q.size(), total);
                    errors++;
                end
            for (int b = 0; b < total && b < bits_q.size(); b++) begin
                assert (bits_q[b] == stream[b])
                    else begin
                        $display("MISMATCH %0t: packet %0d bit %0d is %0b, expected %0b",
                                 $time, idx, b, bits_q[b], stream[b]);
                        errors++;
                    end
            end
            assert (pn_seen)
                else begin
                    $display("packet %0d never raised o_pn_valid", idx);
                    errors++;
                end
            if (pn_seen) begin
                assert (pn_got == exp_off)
                    else begin
                        $display("MISMATCH %0t: packet %0d pn offset %0d, expected %0d",
                                 $time, idx, pn_got, exp_off);
                        errors++;
                    end
            end
            if (r.tx_disable) begin
                assert (!en_seen && !key_seen)
                    else begin
                        $display("transmitter was active in packet %0d with tx_disable set",
                                 idx);
                        errors++;
                    end
            end else begin
                assert (chips_q.size() == r.wait_chips + TX_BITS * TX_CHIPS_PER_BIT)
                    else begin
                        $display("MISMATCH %0t: packet %0d recorded %0d tx chips, expected %0d",
                                 $time, idx, chips_q.size(),
                                 r.wait_chips + TX_BITS * TX_CHIPS_PER_BIT);
                        errors++;
                    end
                for (int c = 0; c < chips_q.size(); c++) begin
                    if (c < r.wait_chips) begin
                        exp_key = 1'b0;
                    end else begin
                        n = (c - r.wait_chips) / TX_CHIPS_PER_BIT;
                        exp_key = r.tx_word[n] ? (((c - r.wait_chips) % 4) < 2)
                                               : (((c - r.wait_chips) % 4) >= 2);
                    end
                    assert (chips_q[c] == exp_key)
                        else begin
                            $display("MISMATCH %0t: packet %0d tx chip %0d key %0b, expected %0b",
                                     $time, idx, c, chips_q[c], exp_key);
                            errors++;
                        end
                end
            end
            if (errors == start_errors) begin
                passed++;
                $display("packet %0d: ok (%0d bits, offset %0d)", idx, total, exp_off);
            end else begin
                failed++;
                $display("packet %0d: FAILED with %0d errors", idx, errors - start_errors);
            end
        end
    endtask

    initial begin
        seed           = 32'h753c;
        errors         = 0;
        passed         = 0;
        failed         = 0;
        timed_out      = 1'b0;
        mon_on         = 1'b0;
        pn_seen        = 1'b0;
        pn_got         = '0;
        en_seen        = 1'b0;
        key_seen       = 1'b0;
        rst            = 1'b1;
        i_sample       = '0;
        i_sample_valid = 1'b0;
        i_fm_flag      = 1'b0;
        i_cfg          = '0;
        table_rows[0] = '{16'h0000, 5'd0, 8'd45, 64'hC3A5_1E0F_9B27_64D1, 16'd6,
                          32'hA5C3_0F1E, 1'b0};
        table_rows[1] = '{16'h0005, 5'd3, 8'd40, 64'h0F0F_3C3C_5A5A_9669, 16'd0,
                          32'hDEAD_BEEF, 1'b0};
        // payload repeats the PN sequence so offsets 0 and 15 tie
        table_rows[2] = '{16'h0000, 5'd0, 8'd44, 64'h1234_5678_9ABC_7AC8, 16'd3,
                          32'h1234_5678, 1'b0};
        table_rows[3] = '{16'h0059, 5'd7, 8'd38, 64'h8E3C_71D2_46AB_0F35, 16'd5,
                          32'hFFFF_0000, 1'b1};
        table_rows[4] = '{16'h2A5B, 5'd15, 8'd30, 64'h6B1D_93E4_C2F0_0A57, 16'd2,
                          32'h8000_0001, 1'b0};
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        for (int t = 0; t < NUM_ROWS && !timed_out; t++) begin
            run_packet(t);
            repeat (5) @(posedge clk);
            #1;
        end
        $display("packets passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== mrr_loopback.f ====
verilog/mrr_loopback_pkg.sv
verilog/chip_timer.sv
verilog/chip_energy.sv
verilog/pn_search.sv
verilog/loopback_ctrl.sv
verilog/mrr_loopback_top.sv
verification/mrr_loopback_chk.sv
verification/mrr_loopback_tb.sv

// ==== Bender.yml ====
package:
  name: mrr_loopback

sources:
  - verilog/mrr_loopback_pkg.sv
  - verilog/chip_timer.sv
  - verilog/chip_energy.sv
  - verilog/pn_search.sv
  - verilog/loopback_ctrl.sv
  - verilog/mrr_loopback_top.sv
  - target: simulation
    files:
      - verification/mrr_loopback_chk.sv
      - verification/mrr_loopback_tb.sv
